// File: sprite_pkg.sv
`default_nettype none

package sprite_pkg;

	// beam coordinate width, good for up to 1024 clocks per line
	localparam int COORD_W = 10;

	// car sprite geometry, fixed
	localparam int SPRITE_SIZE = 16;                 // 16x16 on screen
	localparam int SPRITE_AW = $clog2(SPRITE_SIZE);  // row / column counter width
	localparam int ROM_W = SPRITE_SIZE / 2;          // half width, mirrored for the rest

	// beam position out of video_timing -> sprite pixel out of the renderer
	localparam int PIXEL_LATENCY = 2;

	// APB register map, byte offsets
	localparam logic [3:0] REG_POS_X  = 4'd0;
	localparam logic [3:0] REG_POS_Y  = 4'd4;
	localparam logic [3:0] REG_COLOUR = 4'd8;   // fg in 2..0, bg in 6..4
	localparam logic [3:0] REG_FRAMES = 4'd12;  // read only

	// one beam position
	typedef struct packed {
		logic               hsync;
		logic               vsync;
		logic               display_on;  // inside visible area
		logic [COORD_W-1:0] hpos;
		logic [COORD_W-1:0] vpos;
	} video_t;

	// top-left corner of the sprite
	typedef struct packed {
		logic [COORD_W-1:0] x;
		logic [COORD_W-1:0] y;
	} sprite_pos_t;

	typedef struct packed {
		logic [2:0] fg;  // sprite pixels
		logic [2:0] bg;  // everything else on screen
	} colour_t;

	// host -> slave
	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [3:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	// slave -> host
	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

endpackage

`default_nettype wire

// File: video_timing.sv
`timescale 1ns/1ps
`default_nettype none

module video_timing #(
	parameter int H_DISPLAY = 64,
	parameter int H_FRONT   = 4,
	parameter int H_SYNC    = 8,
	parameter int H_BACK    = 4,
	parameter int V_DISPLAY = 48,
	parameter int V_FRONT   = 2,
	parameter int V_SYNC    = 2,
	parameter int V_BACK    = 2
) (
	input  wire                clk,
	input  wire                reset,
	output sprite_pkg::video_t video
);

	localparam int W = sprite_pkg::COORD_W;

	localparam int H_TOTAL      = H_DISPLAY + H_FRONT + H_SYNC + H_BACK;
	localparam int H_SYNC_START = H_DISPLAY + H_FRONT;
	localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;  // first clock after sync
	localparam int V_TOTAL      = V_DISPLAY + V_FRONT + V_SYNC + V_BACK;
	localparam int V_SYNC_START = V_DISPLAY + V_FRONT;
	localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

	logic [W-1:0] hcount;  // free running beam counters
	logic [W-1:0] vcount;
	logic         h_last;  // last clock of a line
	logic         v_last;

	assign h_last = hcount == W'(H_TOTAL - 1);
	assign v_last = vcount == W'(V_TOTAL - 1);

	always_ff @(posedge clk) begin
		if (reset) begin
			hcount <= '0;
			vcount <= '0;
			video  <= '0;  // syncs inactive, display off
		end else begin
			// outputs decoded from the counters, one clock behind them
			video.hpos       <= hcount;
			video.vpos       <= vcount;
			video.display_on <= (hcount < W'(H_DISPLAY)) && (vcount < W'(V_DISPLAY));
			video.hsync      <= (hcount >= W'(H_SYNC_START)) && (hcount < W'(H_SYNC_END));
			video.vsync      <= (vcount >= W'(V_SYNC_START)) && (vcount < W'(V_SYNC_END));
			if (h_last) begin
				hcount <= '0;
				vcount <= v_last ? '0 : vcount + 1'b1;  // wrap at frame end
			end else begin
				hcount <= hcount + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: sprite_regs.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_regs (
	input  wire                     clk,
	input  wire                     reset,
	input  wire sprite_pkg::apb_req_t apb_req,
	output sprite_pkg::apb_rsp_t    apb_rsp,
	input  wire sprite_pkg::video_t video,
	output sprite_pkg::sprite_pos_t pos,     // active copy, stable for a whole frame
	output sprite_pkg::colour_t     colour
);

	localparam int W = sprite_pkg::COORD_W;

	sprite_pkg::sprite_pos_t pos_wr;     // host written, waits for frame start
	sprite_pkg::colour_t     colour_wr;
	logic [31:0]             frames;     // frame starts since reset
	logic [31:0]             rdata;
	logic                    access;     // APB access phase
	logic                    mapped;
	logic                    err;
	logic                    wr_en;
	logic                    frame_start;

	assign access = apb_req.psel && apb_req.penable;

	// first visible pixel of a frame, display_on keeps the reset value out
	assign frame_start = video.display_on && (video.hpos == '0) && (video.vpos == '0);

	// read mux, unused bits stay zero
	always_comb begin
		mapped = 1'b1;
		case (apb_req.paddr)
			sprite_pkg::REG_POS_X:  rdata = {{(32 - W){1'b0}}, pos_wr.x};
			sprite_pkg::REG_POS_Y:  rdata = {{(32 - W){1'b0}}, pos_wr.y};
			sprite_pkg::REG_COLOUR: rdata = {25'b0, colour_wr.bg, 1'b0, colour_wr.fg};
			sprite_pkg::REG_FRAMES: rdata = frames;
			default: begin
				mapped = 1'b0;
				rdata  = '0;
			end
		endcase
	end

	// unmapped offset or write to the read-only counter
	assign err   = access && (!mapped || (apb_req.pwrite && apb_req.paddr == sprite_pkg::REG_FRAMES));
	assign wr_en = access && apb_req.pwrite && !err;

	always_comb begin
		apb_rsp.prdata  = rdata;
		apb_rsp.pready  = access;  // no wait states
		apb_rsp.pslverr = err;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pos_wr    <= '0;
			colour_wr <= '0;
			pos       <= '0;
			colour    <= '0;
			frames    <= '0;
		end else begin
			if (wr_en) begin
				case (apb_req.paddr)
					sprite_pkg::REG_POS_X: pos_wr.x <= apb_req.pwdata[W-1:0];
					sprite_pkg::REG_POS_Y: pos_wr.y <= apb_req.pwdata[W-1:0];
					sprite_pkg::REG_COLOUR: begin
						colour_wr.fg <= apb_req.pwdata[2:0];
						colour_wr.bg <= apb_req.pwdata[6:4];
					end
					default: ;  // REG_FRAMES never gets here
				endcase
			end
			// swap in new settings only between frames, no tearing
			if (frame_start) begin
				pos    <= pos_wr;
				colour <= colour_wr;
				frames <= frames + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: car_rom.sv
`timescale 1ns/1ps
`default_nettype none

module car_rom (
	input  wire  [sprite_pkg::SPRITE_AW-1:0] row,
	output logic [sprite_pkg::ROM_W-1:0]     bits
);

	// left half of the car, bit 0 = outer edge, bit 7 = centre line
	always_comb begin
		case (row)
			4'd0:    bits = 8'b11110000;  // nose
			4'd1:    bits = 8'b11111000;
			4'd2:    bits = 8'b11111011;  // front wheels
			4'd3:    bits = 8'b11111011;
			4'd4:    bits = 8'b11111011;
			4'd5:    bits = 8'b10001000;  // windscreen
			4'd6:    bits = 8'b10001000;
			4'd7:    bits = 8'b11111000;  // roof
			4'd8:    bits = 8'b11111000;
			4'd9:    bits = 8'b11111000;
			4'd10:   bits = 8'b10001000;  // rear window
			4'd11:   bits = 8'b11111011;  // rear wheels
			4'd12:   bits = 8'b11111011;
			4'd13:   bits = 8'b11111011;
			4'd14:   bits = 8'b11111000;
			default: bits = 8'b11110000;  // tail, row 15
		endcase
	end

endmodule

`default_nettype wire

// File: sprite_renderer.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_renderer (
	input  wire                         clk,
	input  wire                         reset,
	input  wire sprite_pkg::video_t     video,
	input  wire sprite_pkg::sprite_pos_t pos,
	output logic                        pixel  // PIXEL_LATENCY behind video
);

	localparam int AW = sprite_pkg::SPRITE_AW;
	localparam logic [AW-1:0] LAST = AW'(sprite_pkg::SPRITE_SIZE - 1);

	typedef enum logic [2:0] {
		WAIT_VSTART,  // idle until hsync of the line above the sprite
		WAIT_LOAD,    // between rows, wait for the sync area
		LOAD_SETUP,   // present row address to the ROM
		LOAD_FETCH,   // latch ROM bits
		WAIT_HSTART,  // wait for the sprite's left column
		DRAW
	} state_t;

	state_t                      state;
	logic                        hsync_q;
	logic                        hsync_rise;  // start of sync area
	logic                        hstart_q;    // registered column compare
	logic [AW-1:0]               xcount;      // column within the row
	logic [AW-1:0]               ycount;      // sprite row
	logic [AW-1:0]               rom_addr;
	logic [sprite_pkg::ROM_W-1:0] rom_bits;
	logic [sprite_pkg::ROM_W-1:0] outbits;    // current row
	logic [AW-2:0]               bit_idx;

	car_rom u_rom (
		.row (rom_addr),
		.bits(rom_bits)
	);

	assign hsync_rise = video.hsync && !hsync_q;

	// right half reads the row backwards
	assign bit_idx = xcount[AW-1] ? ~xcount[AW-2:0] : xcount[AW-2:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= WAIT_VSTART;
			pixel    <= 1'b0;
			hsync_q  <= 1'b0;
			hstart_q <= 1'b0;
			xcount   <= '0;
			ycount   <= '0;
		end else begin
			hsync_q  <= video.hsync;
			hstart_q <= video.hpos == pos.x;  // seen one clock late
			pixel    <= 1'b0;                 // off unless drawing
			case (state)
				WAIT_VSTART: begin
					ycount <= '0;
					xcount <= '0;
					// pos only changes at frame start, far from any sync area
					if (hsync_rise && video.vpos == pos.y)
						state <= LOAD_SETUP;
				end
				WAIT_LOAD: begin
					xcount <= '0;
					if (hsync_rise)
						state <= LOAD_SETUP;
				end
				LOAD_SETUP: begin
					rom_addr <= ycount;
					state    <= LOAD_FETCH;
				end
				LOAD_FETCH: begin
					outbits <= rom_bits;
					state   <= WAIT_HSTART;
				end
				WAIT_HSTART: begin
					// column 0 goes out here so the compare register costs nothing extra
					if (hstart_q) begin
						pixel  <= outbits[bit_idx];
						xcount <= xcount + 1'b1;
						state  <= DRAW;
					end
				end
				DRAW: begin
					pixel  <= outbits[bit_idx];
					xcount <= xcount + 1'b1;
					if (xcount == LAST) begin  // row done
						ycount <= ycount + 1'b1;
						state  <= (ycount == LAST) ? WAIT_VSTART : WAIT_LOAD;
					end
				end
				default: state <= WAIT_VSTART;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: pixel_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_mixer (
	input  wire                      clk,
	input  wire                      reset,
	input  wire sprite_pkg::video_t  video,
	input  wire                      pixel,
	input  wire sprite_pkg::colour_t colour,
	output sprite_pkg::video_t       video_out,
	output logic [2:0]               rgb
);

	localparam int L = sprite_pkg::PIXEL_LATENCY;

	sprite_pkg::video_t delay_q [L];  // beam position, catches up with pixel

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < L; i++)
				delay_q[i] <= '0;
			video_out <= '0;
			rgb       <= '0;
		end else begin
			delay_q[0] <= video;
			for (int i = 1; i < L; i++)
				delay_q[i] <= delay_q[i-1];
			video_out <= delay_q[L-1];
			if (!delay_q[L-1].display_on)
				rgb <= '0;  // blanking is black
			else if (pixel)
				rgb <= colour.fg;
			else
				rgb <= colour.bg;
		end
	end

endmodule

`default_nettype wire

// File: sprite_top.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_top #(
	parameter int H_DISPLAY = 64,
	parameter int H_FRONT   = 4,
	parameter int H_SYNC    = 8,
	parameter int H_BACK    = 4,
	parameter int V_DISPLAY = 48,
	parameter int V_FRONT   = 2,
	parameter int V_SYNC    = 2,
	parameter int V_BACK    = 2
) (
	input  wire                       clk,
	input  wire                       reset,
	input  wire sprite_pkg::apb_req_t apb_req,
	output sprite_pkg::apb_rsp_t      apb_rsp,
	output sprite_pkg::video_t        video_out,  // aligned with rgb
	output logic [2:0]                rgb
);

	sprite_pkg::video_t      video;   // raw beam
	sprite_pkg::sprite_pos_t pos;     // active for this frame
	sprite_pkg::colour_t     colour;
	logic                    pixel;

	video_timing #(
		.H_DISPLAY(H_DISPLAY), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_DISPLAY(V_DISPLAY), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
	) u_timing (
		.clk  (clk),
		.reset(reset),
		.video(video)
	);

	sprite_regs u_regs (
		.clk    (clk),
		.reset  (reset),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.video  (video),
		.pos    (pos),
		.colour (colour)
	);

	sprite_renderer u_renderer (
		.clk  (clk),
		.reset(reset),
		.video(video),
		.pos  (pos),
		.pixel(pixel)
	);

	pixel_mixer u_mixer (
		.clk      (clk),
		.reset    (reset),
		.video    (video),
		.pixel    (pixel),
		.colour   (colour),
		.video_out(video_out),
		.rgb      (rgb)
	);

endmodule

`default_nettype wire

// File: sprite_chk.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_chk (
	input wire                       clk,
	input wire                       reset,
	input wire sprite_pkg::apb_req_t apb_req,
	input wire sprite_pkg::apb_rsp_t apb_rsp,
	input wire sprite_pkg::video_t   video_out,
	input wire [2:0]                 rgb
);

	logic access;  // APB access phase
	assign access = apb_req.psel && apb_req.penable;

	a_blank_black: assert property (@(posedge clk) disable iff (reset)
		!video_out.display_on |-> rgb == 3'd0)
		else $error("rgb not black during blanking");

	a_no_wait: assert property (@(posedge clk) disable iff (reset)
		access |-> apb_rsp.pready)
		else $error("pready low in an access phase");

	a_err_in_access: assert property (@(posedge clk) disable iff (reset)
		!access |-> !apb_rsp.pslverr)
		else $error("pslverr high outside an access phase");

	// sync pulse lives in the blanking area only
	a_hsync_blank: assert property (@(posedge clk) disable iff (reset)
		video_out.display_on |-> !video_out.hsync)
		else $error("hsync inside the visible area");

endmodule

bind sprite_top sprite_chk u_chk (
	.clk      (clk),
	.reset    (reset),
	.apb_req  (apb_req),
	.apb_rsp  (apb_rsp),
	.video_out(video_out),
	.rgb      (rgb)
);

`default_nettype wire

// File: tb_sprite_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sprite_top;

	localparam int H_DISPLAY = 64;
	localparam int H_FRONT   = 4;
	localparam int H_SYNC    = 8;
	localparam int H_BACK    = 4;
	localparam int V_DISPLAY = 48;
	localparam int V_FRONT   = 2;
	localparam int V_SYNC    = 2;
	localparam int V_BACK    = 2;

	localparam int H_TOTAL      = H_DISPLAY + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL      = V_DISPLAY + V_FRONT + V_SYNC + V_BACK;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam int APB_TIMEOUT  = 16;   // cycles to wait for pready
	localparam int MID_LINE     = V_DISPLAY / 2;

	// car bitmap with row 15 first and bit 0 on the outer edge
	localparam logic [15:0][7:0] CAR = {
		8'hF0, 8'hF8, 8'hFB, 8'hFB, 8'hFB, 8'h88, 8'hF8, 8'hF8,
		8'hF8, 8'h88, 8'h88, 8'hFB, 8'hFB, 8'hFB, 8'hF8, 8'hF0
	};

	logic                    clk;
	logic                    reset;
	sprite_pkg::apb_req_t    apb_req;
	sprite_pkg::apb_rsp_t    apb_rsp;
	sprite_pkg::video_t      video_out;
	logic [2:0]              rgb;

	sprite_pkg::sprite_pos_t wr_pos;      // model of the host written registers
	sprite_pkg::colour_t     wr_colour;
	sprite_pkg::sprite_pos_t act_pos;     // what the current output frame should show
	sprite_pkg::colour_t     act_colour;
	int                      out_frames = 0;  // frame starts seen on video_out
	logic                    beam_locked = 1'b0;  // beam followed from the first frame start
	int                      beam_h = 0;      // expected beam position on video_out
	int                      beam_v = 0;
	int                      pixel_errors = 0;
	int                      video_errors = 0;
	int                      reg_errors = 0;
	int                      protocol_errors = 0;
	int                      timeouts = 0;
	string                   test_name = "reset";

	sprite_top #(
		.H_DISPLAY(H_DISPLAY), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_DISPLAY(V_DISPLAY), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
	) i_dut (
		.clk      (clk),
		.reset    (reset),
		.apb_req  (apb_req),
		.apb_rsp  (apb_rsp),
		.video_out(video_out),
		.rgb      (rgb)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// expected rgb for one beam position
	function automatic logic [2:0] pixel_ref(sprite_pkg::video_t v, sprite_pkg::sprite_pos_t p,
		sprite_pkg::colour_t c);
		int   col;
		int   row;
		logic on;
		col = int'(v.hpos) - int'(p.x);
		row = int'(v.vpos) - (int'(p.y) + 1);  // first row shows a line below y
		on  = 1'b0;
		if (col >= 0 && col < 16 && row >= 0 && row < 16)
			on = (col < 8) ? CAR[row][col] : CAR[row][15 - col];  // right half mirrored
		if (!v.display_on)
			return 3'd0;
		return on ? c.fg : c.bg;
	endfunction

	// expected sync and display flags for one beam position
	function automatic sprite_pkg::video_t video_ref(int h, int v);
		sprite_pkg::video_t e;
		e.hpos       = 10'(h);
		e.vpos       = 10'(v);
		e.display_on = (h < H_DISPLAY) && (v < V_DISPLAY);
		e.hsync      = (h >= H_DISPLAY + H_FRONT) && (h < H_DISPLAY + H_FRONT + H_SYNC);
		e.vsync      = (v >= V_DISPLAY + V_FRONT) && (v < V_DISPLAY + V_FRONT + V_SYNC);
		return e;
	endfunction

	// first visible pixel of a frame on video_out
	function automatic logic at_frame_start();
		return video_out.display_on && video_out.hpos == '0 && video_out.vpos == '0;
	endfunction

	// unmapped offset or a write to the frame counter
	function automatic logic expect_err(logic [3:0] addr, logic write);
		logic mapped;
		mapped = addr == sprite_pkg::REG_POS_X || addr == sprite_pkg::REG_POS_Y ||
			addr == sprite_pkg::REG_COLOUR || addr == sprite_pkg::REG_FRAMES;
		return !mapped || (write && addr == sprite_pkg::REG_FRAMES);
	endfunction

	function automatic logic [31:0] colour_word(logic [2:0] fg, logic [2:0] bg);
		return {25'b0, bg, 1'b0, fg};
	endfunction

	task automatic finish_run();
		$display("summary: %0d pixel, %0d video, %0d register, %0d protocol errors, %0d timeouts",
			pixel_errors, video_errors, reg_errors, protocol_errors, timeouts);
		if (pixel_errors + video_errors + reg_errors + protocol_errors + timeouts == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	endtask

	task automatic report_timeout(string what);
		$display("TIMEOUT in %s: %s", test_name, what);
		timeouts++;
		finish_run();
	endtask

	task automatic check_rgb(string name, logic [2:0] exp, logic [2:0] act);
		if (act !== exp) begin
			pixel_errors++;
			$display("ERROR %s: rgb at (%0d,%0d) expected %0d actual %0d",
				name, video_out.hpos, video_out.vpos, exp, act);
		end
	endtask

	task automatic check_video(string name, sprite_pkg::video_t exp, sprite_pkg::video_t act);
		if (act !== exp) begin
			video_errors++;
			$display("ERROR %s: video_out expected 0x%06h actual 0x%06h", name, exp, act);
		end
	endtask

	task automatic check_word(string name, logic [31:0] exp, logic [31:0] act);
		if (act !== exp) begin
			reg_errors++;
			$display("ERROR %s: prdata expected 0x%08h actual 0x%08h", name, exp, act);
		end
	endtask

	task automatic check_err(string name, logic exp, logic act);
		if (act !== exp) begin
			reg_errors++;
			$display("ERROR %s: pslverr expected %0b actual %0b", name, exp, act);
		end
	endtask

	// one APB transfer with setup and access phase
	task automatic transfer(logic write, logic [3:0] addr, logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		int n;
		@(negedge clk);
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = write;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(negedge clk);
		apb_req.penable = 1'b1;
		n = 0;
		do begin
			@(posedge clk);  // pready settled since the falling edge
			n++;
		end while (!apb_rsp.pready && n < APB_TIMEOUT);
		if (!apb_rsp.pready) begin
			report_timeout("no pready in the APB access phase");
		end else begin
			rdata = apb_rsp.prdata;
			err   = apb_rsp.pslverr;
			if (write && !expect_err(addr, 1'b1)) begin  // register model
				case (addr)
					sprite_pkg::REG_POS_X: wr_pos.x = wdata[9:0];
					sprite_pkg::REG_POS_Y: wr_pos.y = wdata[9:0];
					sprite_pkg::REG_COLOUR: begin
						wr_colour.fg = wdata[2:0];
						wr_colour.bg = wdata[6:4];
					end
					default: ;
				endcase
			end
			@(negedge clk);
			apb_req.psel    = 1'b0;
			apb_req.penable = 1'b0;
		end
	endtask

	task automatic program_reg(string name, logic [3:0] addr, logic [31:0] data);
		logic [31:0] unused;
		logic        err;
		transfer(1'b1, addr, data, unused, err);
		check_err(name, expect_err(addr, 1'b1), err);
	endtask

	task automatic verify_reg(string name, logic [3:0] addr, logic [31:0] exp);
		logic [31:0] data;
		logic        err;
		transfer(1'b0, addr, 32'd0, data, err);
		check_err(name, expect_err(addr, 1'b0), err);
		check_word(name, exp, data);
	endtask

	task automatic set_sprite(int x, int y, logic [2:0] fg, logic [2:0] bg);
		program_reg(test_name, sprite_pkg::REG_POS_X, 32'(x));
		program_reg(test_name, sprite_pkg::REG_POS_Y, 32'(y));
		program_reg(test_name, sprite_pkg::REG_COLOUR, colour_word(fg, bg));
	endtask

	// start of a given output line
	task automatic skip_to_line(int line);
		int n;
		n = 0;
		@(negedge clk);
		while (n < 2 * FRAME_CYCLES &&
			!(int'(video_out.vpos) == line && video_out.hpos == '0)) begin
			n++;
			@(negedge clk);
		end
		if (!(int'(video_out.vpos) == line && video_out.hpos == '0))
			report_timeout("output line never reached");
	endtask

	task automatic wait_frame();
		int n;
		n = 0;
		@(negedge clk);
		while (n < 2 * FRAME_CYCLES && !at_frame_start()) begin
			n++;
			@(negedge clk);
		end
		if (!at_frame_start())
			report_timeout("no frame start on video_out");
	endtask

	// every output cycle against the reference
	always @(negedge clk) begin
		if (!reset) begin
			if (at_frame_start()) begin
				act_pos     = wr_pos;     // registers land at frame start
				act_colour  = wr_colour;
				beam_locked = 1'b1;
				out_frames++;
			end
			check_rgb(test_name, pixel_ref(video_out, act_pos, act_colour), rgb);
			if (beam_locked) begin
				check_video(test_name, video_ref(beam_h, beam_v), video_out);
				beam_h++;
				if (beam_h == H_TOTAL) begin  // next line
					beam_h = 0;
					beam_v = (beam_v + 1) % V_TOTAL;
				end
			end
			if (video_out.display_on && video_out.hsync) begin
				protocol_errors++;
				$display("hsync is high inside the visible area at line %0d", video_out.vpos);
			end
		end
	end

	// APB response at the rising edge
	always @(posedge clk) begin
		if (!reset) begin
			if (apb_req.psel && apb_req.penable && !apb_rsp.pready) begin
				protocol_errors++;
				$display("pready is low in an APB access phase");
			end
			if (!(apb_req.psel && apb_req.penable) && apb_rsp.pslverr) begin
				protocol_errors++;
				$display("pslverr is high outside an APB access phase");
			end
		end
	end

	initial begin
		logic [31:0] f0;
		logic [31:0] f1;
		logic        err;
		int          c0;
		void'($urandom(32'h4d74871d));
		reset      = 1'b1;
		apb_req    = '0;
		wr_pos     = '0;
		wr_colour  = '0;
		act_pos    = '0;
		act_colour = '0;
		repeat (10) @(negedge clk);
		reset = 1'b0;

		test_name = "reset_values";
		verify_reg(test_name, sprite_pkg::REG_POS_X, 32'd0);
		verify_reg(test_name, sprite_pkg::REG_POS_Y, 32'd0);
		verify_reg(test_name, sprite_pkg::REG_COLOUR, 32'd0);
		skip_to_line(MID_LINE);
		verify_reg(test_name, sprite_pkg::REG_FRAMES, 32'(out_frames));
		wait_frame();  // first frame all black

		test_name = "register_access";
		skip_to_line(10);
		program_reg(test_name, sprite_pkg::REG_POS_X, 32'hFFFF_FC15);
		verify_reg(test_name, sprite_pkg::REG_POS_X, 32'h0000_0015);
		program_reg(test_name, sprite_pkg::REG_POS_Y, 32'hABCD_0005);
		verify_reg(test_name, sprite_pkg::REG_POS_Y, 32'h0000_0005);
		program_reg(test_name, sprite_pkg::REG_COLOUR, 32'h1234_56A3);
		verify_reg(test_name, sprite_pkg::REG_COLOUR, 32'h0000_0023);
		transfer(1'b0, sprite_pkg::REG_FRAMES, 32'd0, f0, err);
		check_err(test_name, 1'b0, err);
		program_reg(test_name, sprite_pkg::REG_FRAMES, 32'h0000_5555);  // read only
		program_reg(test_name, 4'h6, 32'h0000_03FF);
		program_reg(test_name, 4'hF, 32'hFFFF_FFFF);
		verify_reg(test_name, 4'h2, 32'd0);
		verify_reg(test_name, sprite_pkg::REG_POS_X, 32'h0000_0015);
		verify_reg(test_name, sprite_pkg::REG_POS_Y, 32'h0000_0005);
		verify_reg(test_name, sprite_pkg::REG_COLOUR, 32'h0000_0023);
		verify_reg(test_name, sprite_pkg::REG_FRAMES, f0);
		wait_frame();
		wait_frame();

		test_name = "sprite_draw";
		skip_to_line(MID_LINE);
		set_sprite(40, 12, 3'd6, 3'd1);
		wait_frame();
		wait_frame();

		test_name = "mid_frame_move";
		skip_to_line(18);  // sprite rows 13..28 being drawn now
		program_reg(test_name, sprite_pkg::REG_POS_X, 32'd8);
		program_reg(test_name, sprite_pkg::REG_POS_Y, 32'd28);
		wait_frame();
		wait_frame();

		test_name = "random_frames";
		repeat (8) begin
			skip_to_line(MID_LINE);
			set_sprite($urandom % (H_DISPLAY - 15), $urandom % (V_DISPLAY - 17),
				3'($urandom), 3'($urandom));
			wait_frame();
		end
		wait_frame();

		test_name = "frame_counter";
		skip_to_line(MID_LINE);  // away from both frame starts
		transfer(1'b0, sprite_pkg::REG_FRAMES, 32'd0, f0, err);
		check_err(test_name, 1'b0, err);
		c0 = out_frames;
		repeat (3) wait_frame();
		skip_to_line(MID_LINE);
		transfer(1'b0, sprite_pkg::REG_FRAMES, 32'd0, f1, err);
		check_err(test_name, 1'b0, err);
		check_word(test_name, f0 + 32'(out_frames - c0), f1);

		finish_run();
	end

endmodule

`default_nettype wire

// File: project.f
sprite_pkg.sv
video_timing.sv
sprite_regs.sv
car_rom.sv
sprite_renderer.sv
pixel_mixer.sv
sprite_top.sv
sprite_chk.sv
tb_sprite_top.sv

// File: Bender.yml
package:
  name: sprite_engine

sources:
  - sprite_pkg.sv
  - video_timing.sv
  - sprite_regs.sv
  - car_rom.sv
  - sprite_renderer.sv
  - pixel_mixer.sv
  - sprite_top.sv
  - target: simulation
    files:
      - sprite_chk.sv
      - tb_sprite_top.sv
